/* include/psl_consts.svh */
/*
  Widths, queue depth and response delay of the host link model.
  Queues hold 2**FIFO_AW entries; the source must stay within that.
*/
`ifndef PSL_CONSTS_SVH
`define PSL_CONSTS_SVH

// Command tags
`define TAG_W 8
`define NUM_TAGS 256

// Buffer-write line, split into two half beats on the way out
`define LINE_W 1024
`define LINE_PAR_W 16

// Response fields
`define RESP_W 8
`define CRED_W 9

// Queue depth of 64 entries
`define FIFO_AW 6
// Pending lines per tag
`define BW_CNT_W 7

`define RESP_DELAY 3

`endif

/* logic/psl_pkg.sv */
/*
  Types of the host link model. Vectors are numbered from bit 0 at the left,
  so the first half of a line and its parity sit in the low-numbered bits.
*/
`include "psl_consts.svh"

package psl_pkg;

  typedef logic [0:`TAG_W-1]        tag_t;
  typedef logic [0:`LINE_W-1]       line_t;
  typedef logic [0:`LINE_W/2-1]     half_t;
  typedef logic [0:`LINE_PAR_W-1]   line_par_t;
  typedef logic [0:`LINE_PAR_W/2-1] half_par_t;
  typedef logic [0:`RESP_W-1]       resp_code_t;
  typedef logic [0:`CRED_W-1]       credits_t;
  typedef logic [0:`BW_CNT_W-1]     bw_cnt_t;

  typedef struct packed {
    tag_t      tag;
    logic      tag_par;
    line_t     data;
    line_par_t par;
  } bw_line_t;

  typedef struct packed {
    tag_t      tag;
    logic      tag_par;
    logic      half_ad;
    half_t     data;
    half_par_t par;
  } bw_beat_t;

  typedef struct packed {
    tag_t       tag;
    logic       tag_par;
    resp_code_t code;
    credits_t   credits;
  } resp_t;

  typedef enum logic [1:0] {BW_IDLE, BW_LOAD, BW_HALF0, BW_HALF1} bw_split_state_t;

endpackage

/* logic/sim_fifo.sv */
/*
  Storage queue of 2**FIFO_AW words with a combinational head word.
  No back-pressure; a push when full or a pop when empty is a source error.
*/
`timescale 1ns/10ps
`include "psl_consts.svh"

module sim_fifo #(
  parameter int WIDTH = 8
) (
  input  logic             ha_pclock,
  input  logic             reset,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] head,
  output logic             empty,
  output logic             full
);

  localparam int DEPTH = 1 << `FIFO_AW;

  logic [WIDTH-1:0] mem [0:DEPTH-1];
  // Extra top bit tells a full queue from an empty one
  logic [`FIFO_AW:0] wr_ptr;
  logic [`FIFO_AW:0] rd_ptr;

  always_ff @(posedge ha_pclock) begin
    if (push) begin
      mem[wr_ptr[`FIFO_AW-1:0]] <= push_data;
    end
  end

  always_ff @(posedge ha_pclock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  assign head  = mem[rd_ptr[`FIFO_AW-1:0]];
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[`FIFO_AW] != rd_ptr[`FIFO_AW]) &&
                 (wr_ptr[`FIFO_AW-1:0] == rd_ptr[`FIFO_AW-1:0]);

  // Source kept more than DEPTH entries outstanding
  a_no_overflow: assert property (@(posedge ha_pclock) disable iff (reset) push |-> !full);
  a_no_underflow: assert property (@(posedge ha_pclock) disable iff (reset) pop |-> !empty);

endmodule

/* logic/bw_queue.sv */
/*
  Buffer-write lines leave in order as two half beats, half 0 then half 1.
  One line per three cycles at best; the first beat comes two edges after
  acceptance at the earliest. Parity is carried, not checked.
*/
`timescale 1ns/10ps
`include "psl_consts.svh"

module bw_queue (
  input  logic               ha_pclock,
  input  logic               reset,
  input  logic               bw_valid,
  input  psl_pkg::bw_line_t  bw_line,
  output logic               beat_valid,
  output psl_pkg::bw_beat_t  beat,
  output logic               line_done,
  output psl_pkg::tag_t      done_tag
);

  import psl_pkg::*;

  bw_split_state_t state;
  bw_split_state_t state_nxt;
  bw_line_t        head_line;
  bw_line_t        hold;
  logic            empty;
  logic            pop;

  sim_fifo #(.WIDTH($bits(bw_line_t))) i_line_fifo (
    .ha_pclock (ha_pclock),
    .reset     (reset),
    .push      (bw_valid),
    .push_data (bw_line),
    .pop       (pop),
    .head      (head_line),
    .empty     (empty),
    .full      ()
  );

  always_comb begin
    state_nxt = state;
    case (state)
      BW_IDLE:  if (!empty) state_nxt = BW_LOAD;
      BW_LOAD:  state_nxt = BW_HALF0;
      BW_HALF0: state_nxt = BW_HALF1;
      BW_HALF1: state_nxt = empty ? BW_IDLE : BW_LOAD;
      default:  state_nxt = BW_IDLE;
    endcase
  end

  always_ff @(posedge ha_pclock) begin
    if (reset) begin
      state <= BW_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Queue is never empty in BW_LOAD
  assign pop = (state == BW_LOAD);

  always_ff @(posedge ha_pclock) begin
    if (pop) begin
      hold <= head_line;
    end
  end

  always_comb begin
    beat.tag     = hold.tag;
    beat.tag_par = hold.tag_par;
    beat.half_ad = (state == BW_HALF1);
    if (state == BW_HALF1) begin
      beat.data = hold.data[`LINE_W/2:`LINE_W-1];
      beat.par  = hold.par[`LINE_PAR_W/2:`LINE_PAR_W-1];
    end else begin
      beat.data = hold.data[0:`LINE_W/2-1];
      beat.par  = hold.par[0:`LINE_PAR_W/2-1];
    end
  end

  assign beat_valid = (state == BW_HALF0) || (state == BW_HALF1);
  assign line_done  = (state == BW_HALF1);
  assign done_tag   = hold.tag;

  // Half 1 of the same line always follows half 0 directly
  a_half_pair: assert property (@(posedge ha_pclock) disable iff (reset)
    beat_valid && !beat.half_ad |=> beat_valid && beat.half_ad && $stable(beat.tag));

endmodule

/* logic/bw_tag_tracker.sv */
/*
  Counts per tag the lines accepted but not yet delivered as a half-1 beat.
  tag_busy is combinational on query_tag.
*/
`timescale 1ns/10ps
`include "psl_consts.svh"

module bw_tag_tracker (
  input  logic          ha_pclock,
  input  logic          reset,
  input  logic          inc_valid,
  input  psl_pkg::tag_t inc_tag,
  input  logic          dec_valid,
  input  psl_pkg::tag_t dec_tag,
  input  psl_pkg::tag_t query_tag,
  output logic          tag_busy
);

  import psl_pkg::*;

  bw_cnt_t cnt [0:`NUM_TAGS-1];
  logic    same_tag;

  // Increment and decrement of one tag cancel out
  assign same_tag = inc_valid && dec_valid && (inc_tag == dec_tag);

  always_ff @(posedge ha_pclock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_TAGS; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      if (inc_valid && !same_tag) begin
        cnt[inc_tag] <= cnt[inc_tag] + 1'b1;
      end
      if (dec_valid && !same_tag) begin
        cnt[dec_tag] <= cnt[dec_tag] - 1'b1;
      end
    end
  end

  assign tag_busy = (cnt[query_tag] != '0);

  // A delivered line must have been counted at acceptance
  a_no_dec_zero: assert property (@(posedge ha_pclock) disable iff (reset)
    dec_valid |-> cnt[dec_tag] != '0);
  a_no_inc_sat: assert property (@(posedge ha_pclock) disable iff (reset)
    inc_valid && !same_tag |-> cnt[inc_tag] != '1);

endmodule

/* logic/resp_queue.sv */
/*
  Responses leave in order. The head waits while its tag still has
  buffer-write lines pending, and holds back everything behind it.
  Output valid rises RESP_DELAY + 1 edges after the head is seen released.
*/
`timescale 1ns/10ps
`include "psl_consts.svh"

module resp_queue (
  input  logic           ha_pclock,
  input  logic           reset,
  input  logic           resp_valid,
  input  psl_pkg::resp_t resp,
  input  logic           tag_busy,
  output psl_pkg::tag_t  query_tag,
  output logic           resp_out_valid,
  output psl_pkg::resp_t resp_out
);

  import psl_pkg::*;

  resp_t head_resp;
  logic  empty;
  logic  release_head;

  // Stage 0 holds the popped entry, then RESP_DELAY stages follow
  logic  vld  [0:`RESP_DELAY];
  resp_t pipe [0:`RESP_DELAY];

  sim_fifo #(.WIDTH($bits(resp_t))) i_resp_fifo (
    .ha_pclock (ha_pclock),
    .reset     (reset),
    .push      (resp_valid),
    .push_data (resp),
    .pop       (release_head),
    .head      (head_resp),
    .empty     (empty),
    .full      ()
  );

  assign query_tag    = head_resp.tag;
  assign release_head = !empty && !tag_busy;

  always_ff @(posedge ha_pclock) begin
    if (reset) begin
      for (int i = 0; i <= `RESP_DELAY; i++) begin
        vld[i] <= 1'b0;
      end
    end else begin
      vld[0] <= release_head;
      for (int i = 1; i <= `RESP_DELAY; i++) begin
        vld[i] <= vld[i-1];
      end
    end
  end

  always_ff @(posedge ha_pclock) begin
    if (release_head) begin
      pipe[0] <= head_resp;
    end
    for (int i = 1; i <= `RESP_DELAY; i++) begin
      pipe[i] <= pipe[i-1];
    end
  end

  assign resp_out_valid = vld[`RESP_DELAY];
  assign resp_out       = pipe[`RESP_DELAY];

endmodule

/* logic/psl_host_top.sv */
/*
  Host side of the accelerator link: buffer-write split, per-tag pending
  count and the tag-gated response path. No back-pressure on any port.
*/
`timescale 1ns/10ps

module psl_host_top (
  input  logic              ha_pclock,
  input  logic              reset,
  input  logic              bw_valid,
  input  psl_pkg::bw_line_t bw_line,
  input  logic              resp_valid,
  input  psl_pkg::resp_t    resp,
  output logic              beat_valid,
  output psl_pkg::bw_beat_t beat,
  output logic              resp_out_valid,
  output psl_pkg::resp_t    resp_out
);

  import psl_pkg::*;

  logic line_done;
  tag_t done_tag;
  tag_t query_tag;
  logic tag_busy;

  bw_queue i_bw_queue (
    .ha_pclock  (ha_pclock),
    .reset      (reset),
    .bw_valid   (bw_valid),
    .bw_line    (bw_line),
    .beat_valid (beat_valid),
    .beat       (beat),
    .line_done  (line_done),
    .done_tag   (done_tag)
  );

  // Count rises on acceptance, falls with the half-1 beat
  bw_tag_tracker i_bw_tag_tracker (
    .ha_pclock (ha_pclock),
    .reset     (reset),
    .inc_valid (bw_valid),
    .inc_tag   (bw_line.tag),
    .dec_valid (line_done),
    .dec_tag   (done_tag),
    .query_tag (query_tag),
    .tag_busy  (tag_busy)
  );

  resp_queue i_resp_queue (
    .ha_pclock      (ha_pclock),
    .reset          (reset),
    .resp_valid     (resp_valid),
    .resp           (resp),
    .tag_busy       (tag_busy),
    .query_tag      (query_tag),
    .resp_out_valid (resp_out_valid),
    .resp_out       (resp_out)
  );

endmodule

/* sim/psl_checker.sv */
/*
  Compares DUT beats and responses with expected queues built from the inputs.
  A line accepted at the same edge as a response counts as ahead of it.
*/
`timescale 1ns/10ps
`include "psl_consts.svh"

module psl_checker (
  input  logic              ha_pclock,
  input  logic              reset,
  input  logic              bw_valid,
  input  psl_pkg::bw_line_t bw_line,
  input  psl_pkg::bw_beat_t exp_beat0,
  input  psl_pkg::bw_beat_t exp_beat1,
  input  logic              resp_valid,
  input  psl_pkg::resp_t    resp,
  input  logic              beat_valid,
  input  psl_pkg::bw_beat_t beat,
  input  logic              resp_out_valid,
  input  psl_pkg::resp_t    resp_out,
  output int                errors,
  output int                beats_checked,
  output int                resps_checked
);

  import psl_pkg::*;

  bw_beat_t beat_q [$];
  resp_t    resp_q [$];
  // Accept edge per line; per response the lines of its tag ahead and a deadline
  int       acc_q [$];
  int       snap_q [$];
  int       due_q [$];
  int       acc_cnt [0:`NUM_TAGS-1];
  int       done_cnt [0:`NUM_TAGS-1];
  int       cyc;
  int       err_cnt = 0;
  int       beat_cnt = 0;
  int       resp_cnt = 0;
  logic     want_half1;

  assign errors        = err_cnt;
  assign beats_checked = beat_cnt;
  assign resps_checked = resp_cnt;

  task automatic check_beat();
    bw_beat_t exp_b;
    int       acc;
    if (beat_q.size() == 0) begin
      $display("ERROR at %0t: beat output with no line outstanding", $time);
      err_cnt++;
    end else begin
      exp_b = beat_q.pop_front();
      beat_cnt++;
      if (beat !== exp_b) begin
        $display("FAILED %0t: half %0d beat of tag %h does not match its line",
                 $time, exp_b.half_ad, exp_b.tag);
        err_cnt++;
      end
      if (exp_b.half_ad) begin
        done_cnt[exp_b.tag]++;
      end else begin
        acc = acc_q.pop_front();
        // Beat sampled here started at the previous edge
        if (cyc - 1 - acc < 2) begin
          $display("FAILED %0t: half-0 beat of tag %h only %0d edges after its line",
                   $time, exp_b.tag, cyc - 1 - acc);
          err_cnt++;
        end
      end
    end
  endtask

  task automatic check_resp();
    resp_t exp_r;
    int    snap;
    int    due;
    if (resp_q.size() == 0) begin
      $display("ERROR at %0t: response output with no response outstanding", $time);
      err_cnt++;
    end else begin
      exp_r = resp_q.pop_front();
      snap  = snap_q.pop_front();
      due   = due_q.pop_front();
      resp_cnt++;
      if (resp_out !== exp_r) begin
        $display("FAILED %0t: response %h, expected %h", $time, resp_out, exp_r);
        err_cnt++;
      end
      if (done_cnt[exp_r.tag] < snap) begin
        $display("FAILED %0t: response of tag %h left with %0d earlier lines undelivered",
                 $time, exp_r.tag, snap - done_cnt[exp_r.tag]);
        err_cnt++;
      end
      if (due >= 0 && cyc > due) begin
        $display("FAILED %0t: unblocked response of tag %h left %0d edges late",
                 $time, exp_r.tag, cyc - due);
        err_cnt++;
      end
    end
  endtask

  task automatic record_inputs();
    int snap;
    if (bw_valid) begin
      beat_q.push_back(exp_beat0);
      beat_q.push_back(exp_beat1);
      acc_q.push_back(cyc);
      acc_cnt[bw_line.tag]++;
    end
    if (resp_valid) begin
      snap = acc_cnt[resp.tag];
      resp_q.push_back(resp);
      snap_q.push_back(snap);
      // Queue empty and nothing pending on its tag
      if (resp_q.size() == 1 && snap == done_cnt[resp.tag]) begin
        due_q.push_back(cyc + 8);
      end else begin
        due_q.push_back(-1);
      end
    end
  endtask

  always @(posedge ha_pclock) begin
    if (reset) begin
      cyc = 0;
      want_half1 = 1'b0;
      for (int i = 0; i < `NUM_TAGS; i++) begin
        acc_cnt[i] = 0;
        done_cnt[i] = 0;
      end
    end else begin
      cyc++;
      if (want_half1 && !(beat_valid && beat.half_ad)) begin
        $display("ERROR at %0t: half-0 beat not directly followed by half 1", $time);
        err_cnt++;
      end
      want_half1 = beat_valid && !beat.half_ad;
      if (beat_valid) begin
        check_beat();
      end
      if (resp_out_valid) begin
        check_resp();
      end
      record_inputs();
    end
  end

endmodule

/* sim/tb_psl_host.sv */
/*
  Random lines and responses from a fixed-seed LCG, with same-tag bursts and
  quiet responses. The source keeps at most 48 lines and 48 responses open.
*/
`timescale 1ns/10ps
`include "psl_consts.svh"

module tb_psl_host;

  import psl_pkg::*;

  localparam int NUM_ITEMS = 300;
  localparam int MAX_OUT   = 48;
  // About three cycles per line plus gaps and drains
  localparam int STIM_LEN       = 5 * NUM_ITEMS;
  localparam int TIMEOUT_CYCLES = 20 * STIM_LEN;

  logic        ha_pclock;
  logic        reset;
  logic        bw_valid;
  bw_line_t    bw_line;
  bw_beat_t    exp_beat0;
  bw_beat_t    exp_beat1;
  logic        resp_valid;
  resp_t       resp;
  logic        beat_valid;
  bw_beat_t    beat;
  logic        resp_out_valid;
  resp_t       resp_out;
  int          errors;
  int          beats_checked;
  int          resps_checked;
  logic [31:0] seed = 32'h63dfcfab;
  logic [31:0] sel;
  int          lines_sent = 0;
  int          resps_sent = 0;
  int          lines_out = 0;
  int          resps_out = 0;
  int          cycles = 0;

  psl_host_top i_dut (.*);

  psl_checker i_checker (.*);

  function automatic logic [31:0] rand32();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic tag_t tag_of(logic [2:0] k);
    return tag_t'({k, 5'h0b});
  endfunction

  // Half 0 carries the low-numbered data and parity bits
  function automatic bw_beat_t split_line(bw_line_t l, logic half);
    bw_beat_t b;
    b.tag     = l.tag;
    b.tag_par = l.tag_par;
    b.half_ad = half;
    b.data    = half ? l.data[`LINE_W/2 +: `LINE_W/2] : l.data[0 +: `LINE_W/2];
    b.par     = half ? l.par[`LINE_PAR_W/2 +: `LINE_PAR_W/2] : l.par[0 +: `LINE_PAR_W/2];
    return b;
  endfunction

  task automatic drive_cycle(logic send_line, tag_t ltag, logic send_resp, tag_t rtag);
    bw_line_t    l;
    resp_t       r;
    logic [31:0] x;
    logic        do_line;
    logic        do_resp;
    for (int i = 0; i < `LINE_W / 32; i++) begin
      l.data[32*i +: 32] = rand32();
    end
    x = rand32();
    l.tag     = ltag;
    l.tag_par = x[31];
    l.par     = x[15:0];
    x = rand32();
    r.tag     = rtag;
    r.tag_par = x[31];
    r.code    = x[7:0];
    r.credits = x[16:8];
    do_line = send_line && (lines_sent < NUM_ITEMS);
    do_resp = send_resp && (resps_sent < NUM_ITEMS);
    @(posedge ha_pclock);
    bw_valid   <= do_line;
    bw_line    <= l;
    exp_beat0  <= split_line(l, 1'b0);
    exp_beat1  <= split_line(l, 1'b1);
    resp_valid <= do_resp;
    resp       <= r;
    if (do_line) begin
      lines_sent++;
    end
    if (do_resp) begin
      resps_sent++;
    end
  endtask

  // Idles until n more lines and responses fit; n of MAX_OUT drains all
  task automatic wait_room(int n);
    while (lines_sent - lines_out > MAX_OUT - n ||
           resps_sent - resps_out > MAX_OUT - n) begin
      drive_cycle(1'b0, '0, 1'b0, '0);
    end
  endtask

  task automatic end_run(logic timed_out);
    if (timed_out) begin
      $display("Timeout: %0d of %0d lines and %0d of %0d responses came out",
               lines_out, lines_sent, resps_out, resps_sent);
    end
    $display("Beats checked %0d, responses checked %0d, errors %0d",
             beats_checked, resps_checked, errors);
    if (timed_out || errors != 0) begin
      $display("STATUS: FAIL");
    end else begin
      $display("STATUS: PASS");
    end
    $finish;
  endtask

  initial begin
    ha_pclock = 1'b0;
    forever #5 ha_pclock = ~ha_pclock;
  end

  always @(posedge ha_pclock) begin
    if (beat_valid && beat.half_ad) begin
      lines_out <= lines_out + 1;
    end
    if (resp_out_valid) begin
      resps_out <= resps_out + 1;
    end
  end

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge ha_pclock);
      cycles++;
    end
    end_run(1'b1);
  end

  initial begin
    reset      = 1'b1;
    bw_valid   = 1'b0;
    bw_line    = '0;
    exp_beat0  = '0;
    exp_beat1  = '0;
    resp_valid = 1'b0;
    resp       = '0;
    repeat (16) @(posedge ha_pclock);
    reset <= 1'b0;
    repeat (16) drive_cycle(1'b0, '0, 1'b0, '0);
    while (lines_sent < NUM_ITEMS || resps_sent < NUM_ITEMS) begin
      sel = rand32();
      wait_room(6);
      if (sel[31:29] == 3'd0) begin
        // Same-tag burst, its response, then one on another tag behind it
        repeat (2 + sel[28:27]) drive_cycle(1'b1, tag_of(sel[26:24]), 1'b0, '0);
        drive_cycle(1'b0, '0, 1'b1, tag_of(sel[26:24]));
        drive_cycle(1'b0, '0, 1'b1, tag_of(sel[23:21]));
      end else if (sel[31:29] == 3'd1) begin
        wait_room(MAX_OUT);
        drive_cycle(1'b0, '0, 1'b1, tag_of(sel[26:24]));
      end else begin
        drive_cycle(sel[20], tag_of(sel[26:24]), sel[19], tag_of(sel[23:21]));
        repeat (sel[18:17]) drive_cycle(1'b0, '0, 1'b0, '0);
      end
    end
    wait_room(MAX_OUT);
    repeat (16) drive_cycle(1'b0, '0, 1'b0, '0);
    end_run(1'b0);
  end

endmodule

/* project.f */
+incdir+include
logic/psl_pkg.sv
logic/sim_fifo.sv
logic/bw_queue.sv
logic/bw_tag_tracker.sv
logic/resp_queue.sv
logic/psl_host_top.sv
sim/psl_checker.sv
sim/tb_psl_host.sv
